//--- exePkg.sv
`default_nettype none

package exePkg;

	localparam int xlen = 32;
	localparam int regAddrBits = 5;

	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluSll  = 4'd2,
		aluSlt  = 4'd3,
		aluSltu = 4'd4,
		aluXor  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluOr   = 4'd8,
		aluAnd  = 4'd9
	} aluOpE;

	// write-back source picked in stage 6
	typedef enum logic [2:0] {
		wbAlu    = 3'd0,
		wbLink   = 3'd1, // pc + 4
		wbMulDiv = 3'd2,
		wbUpper  = 3'd3, // lui
		wbMem    = 3'd4,
		wbAuipc  = 3'd5  // pc + uImm
	} wbSelE;

	typedef enum logic [3:0] {
		memNone = 4'd0,
		memLb   = 4'd1,
		memLh   = 4'd2,
		memLw   = 4'd3,
		memLbu  = 4'd4,
		memLhu  = 4'd5,
		memSb   = 4'd6,
		memSh   = 4'd7,
		memSw   = 4'd8
	} memOpE;

	// same order as RV32M funct3
	typedef enum logic [2:0] {
		mdMul    = 3'd0,
		mdMulh   = 3'd1,
		mdMulhsu = 3'd2,
		mdMulhu  = 3'd3,
		mdDiv    = 3'd4,
		mdDivu   = 3'd5,
		mdRem    = 3'd6,
		mdRemu   = 3'd7
	} mulDivOpE;

	// branch funct3 values with 2 and 3 unused
	typedef enum logic [2:0] {
		brEq  = 3'd0,
		brNe  = 3'd1,
		brLt  = 3'd4,
		brGe  = 3'd5,
		brLtu = 3'd6,
		brGeu = 3'd7
	} brCondE;

endpackage

`default_nettype wire

//--- exeAlu.sv
`default_nettype none

module exeAlu (
	input  exePkg::aluOpE           op,
	input  logic [exePkg::xlen-1:0] a,
	input  logic [exePkg::xlen-1:0] b,
	input  exePkg::brCondE          brCond,
	output logic [exePkg::xlen-1:0] result,
	output logic                    condTrue
);

	logic [4:0] shamt;
	logic       ltSigned;
	logic       ltUnsigned;

	assign shamt      = b[4:0]; // only low five bits count
	assign ltSigned   = $signed(a) < $signed(b);
	assign ltUnsigned = a < b;

	always_comb
	begin
		unique case (op)
			exePkg::aluAdd:  result = a + b;
			exePkg::aluSub:  result = a - b;
			exePkg::aluSll:  result = a << shamt;
			exePkg::aluSlt:  result = exePkg::xlen'(ltSigned);
			exePkg::aluSltu: result = exePkg::xlen'(ltUnsigned);
			exePkg::aluXor:  result = a ^ b;
			exePkg::aluSrl:  result = a >> shamt;
			exePkg::aluSra:  result = $signed(a) >>> shamt; // keeps the sign bit
			exePkg::aluOr:   result = a | b;
			exePkg::aluAnd:  result = a & b;
			default:         result = '0;
		endcase
	end

	// branch compare runs alongside the ALU op
	always_comb
	begin
		unique case (brCond)
			exePkg::brEq:  condTrue = (a == b);
			exePkg::brNe:  condTrue = (a != b);
			exePkg::brLt:  condTrue = ltSigned;
			exePkg::brGe:  condTrue = !ltSigned;
			exePkg::brLtu: condTrue = ltUnsigned;
			exePkg::brGeu: condTrue = !ltUnsigned;
			default:       condTrue = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- mulDiv.sv
`default_nettype none

module mulDiv (
	input  exePkg::mulDivOpE        op,
	input  logic [exePkg::xlen-1:0] a,
	input  logic [exePkg::xlen-1:0] b,
	output logic [exePkg::xlen-1:0] res
);

	localparam int w = exePkg::xlen;

	logic                aSigned;
	logic                bSigned;
	logic signed [w:0]   aExt; // one extra bit carries the sign choice
	logic signed [w:0]   bExt;
	logic signed [2*w+1:0] prod;
	logic                divZero;
	logic                divOvf;

	assign aSigned = (op == exePkg::mdMulh) || (op == exePkg::mdMulhsu);
	assign bSigned = (op == exePkg::mdMulh);
	assign aExt    = {aSigned & a[w-1], a};
	assign bExt    = {bSigned & b[w-1], b};
	assign prod    = aExt * bExt;

	assign divZero = (b == '0);
	assign divOvf  = (a == {1'b1, {(w-1){1'b0}}}) && (b == '1); // most negative / -1

	always_comb
	begin
		unique case (op)
			exePkg::mdMul:    res = prod[w-1:0];
			exePkg::mdMulh,
			exePkg::mdMulhsu,
			exePkg::mdMulhu:  res = prod[2*w-1:w]; // high half
			exePkg::mdDiv:
			begin
				if (divZero)
					res = '1;
				else if (divOvf)
					res = a;
				else
					res = $signed(a) / $signed(b);
			end
			exePkg::mdDivu:   res = divZero ? '1 : a / b;
			exePkg::mdRem:
			begin
				if (divZero)
					res = a;
				else if (divOvf)
					res = '0;
				else
					res = $signed(a) % $signed(b);
			end
			exePkg::mdRemu:   res = divZero ? a : a % b;
			default:          res = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- dataMem.sv
`default_nettype none

module dataMem #(
	parameter int dmemWords = 256
) (
	input  logic                    clk,
	input  logic                    nrst,
	input  exePkg::memOpE           memOp,
	input  logic [exePkg::xlen-1:0] base,
	input  logic [exePkg::xlen-1:0] storeData,
	input  logic [exePkg::xlen-1:0] offset,
	output logic [exePkg::xlen-1:0] memOut6,
	output logic                    addrMisaligned6
);

	localparam int w = exePkg::xlen;
	localparam int idxBits = $clog2(dmemWords);

	logic [w-1:0]       mem [dmemWords];
	logic [w-1:0]       addr;
	logic [idxBits-1:0] wordIdx;
	logic               misaligned;
	logic [3:0]         byteEn;
	logic [w-1:0]       laneData;

	logic [w-1:0]       rdWord5;
	logic [1:0]         lane5;
	exePkg::memOpE      op5;
	logic               misaligned5;
	logic [w-1:0]       shifted;
	logic [w-1:0]       loadVal;

	assign addr    = base + offset;
	assign wordIdx = idxBits'((addr >> 2) % dmemWords); // wraps around the array

	always_comb
	begin
		unique case (memOp)
			exePkg::memLh,
			exePkg::memLhu,
			exePkg::memSh: misaligned = addr[0];
			exePkg::memLw,
			exePkg::memSw: misaligned = |addr[1:0];
			default:       misaligned = 1'b0;
		endcase
	end

	// byte lanes and replicated store data
	always_comb
	begin
		byteEn   = 4'b0000;
		laneData = storeData;
		unique case (memOp)
			exePkg::memSb:
			begin
				byteEn   = 4'b0001 << addr[1:0];
				laneData = {4{storeData[7:0]}};
			end
			exePkg::memSh:
			begin
				byteEn   = 4'b0011 << addr[1:0];
				laneData = {2{storeData[15:0]}};
			end
			exePkg::memSw: byteEn = 4'b1111;
			default:       byteEn = 4'b0000;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!misaligned) // misaligned stores dropped
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (byteEn[i])
					mem[wordIdx][8*i +: 8] <= laneData[8*i +: 8];
			end
		end
	end

	// first load stage holds the raw word and its byte lane
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			rdWord5     <= '0;
			lane5       <= '0;
			op5         <= exePkg::memNone;
			misaligned5 <= 1'b0;
		end
		else
		begin
			rdWord5     <= mem[wordIdx];
			lane5       <= addr[1:0];
			op5         <= memOp;
			misaligned5 <= misaligned;
		end
	end

	assign shifted = rdWord5 >> {lane5, 3'b000};

	always_comb
	begin
		unique case (op5)
			exePkg::memLb:  loadVal = {{24{shifted[7]}}, shifted[7:0]};
			exePkg::memLh:  loadVal = {{16{shifted[15]}}, shifted[15:0]};
			exePkg::memLw:  loadVal = shifted;
			exePkg::memLbu: loadVal = {24'b0, shifted[7:0]};
			exePkg::memLhu: loadVal = {16'b0, shifted[15:0]};
			default:        loadVal = '0; // stores and bubbles
		endcase
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			memOut6         <= '0;
			addrMisaligned6 <= 1'b0;
		end
		else
		begin
			memOut6         <= loadVal;
			addrMisaligned6 <= misaligned5;
		end
	end

endmodule

`default_nettype wire

//--- exeStage.sv
`default_nettype none

module exeStage #(
	parameter int dmemWords = 256
) (
	input  logic                           clk,
	input  logic                           nrst,
	input  logic [exePkg::xlen-1:0]        opA,
	input  logic [exePkg::xlen-1:0]        opB,
	input  logic [exePkg::regAddrBits-1:0] rd,
	input  logic                           we,
	input  exePkg::aluOpE                  aluOp,
	input  exePkg::wbSelE                  wbSel,
	input  logic                           isBranch,
	input  exePkg::brCondE                 brCond,
	input  logic                           isJal,
	input  logic                           isJalr,
	input  logic [exePkg::xlen-1:0]        bImm,
	input  logic [exePkg::xlen-1:0]        jImm,
	input  logic [exePkg::xlen-1:0]        uImm,
	input  logic [exePkg::xlen-1:0]        sImm,
	input  exePkg::memOpE                  memOp,
	input  exePkg::mulDivOpE               mulDivOp,
	input  logic [exePkg::xlen-1:0]        pc,
	output logic [exePkg::xlen-1:0]        wbData,
	output logic                           we6,
	output logic [exePkg::regAddrBits-1:0] rd6,
	output logic [exePkg::xlen-1:0]        memOut6,
	output logic                           addrMisaligned6,
	output logic                           redirect,
	output logic [exePkg::xlen-1:0]        target
);

	localparam int w = exePkg::xlen;

	logic [w-1:0] target4;
	logic         isStore4;
	logic [w-1:0] memOffset4;

	logic [w-1:0]                   opA5;
	logic [w-1:0]                   opB5;
	logic [exePkg::regAddrBits-1:0] rd5;
	logic                           we5;
	exePkg::aluOpE                  aluOp5;
	exePkg::wbSelE                  wbSel5;
	exePkg::brCondE                 brCond5;
	exePkg::mulDivOpE               mulDivOp5;
	logic                           isBranch5;
	logic                           isJump5;
	logic [w-1:0]                   target5;
	logic [w-1:0]                   uImm5;
	logic [w-1:0]                   pc5;
	logic [w-1:0]                   aluRes5;
	logic [w-1:0]                   mulDivRes5;
	logic                           condTrue5;

	logic [w-1:0]  aluRes6;
	logic [w-1:0]  mulDivRes6;
	logic [w-1:0]  pc6;
	logic [w-1:0]  uImm6;
	logic [w-1:0]  auipc6;
	exePkg::wbSelE wbSel6;

	// stage 4 target and memory offset
	always_comb
	begin
		if (isJal)
			target4 = pc + jImm;
		else if (isJalr)
			target4 = (opA + opB) & ~w'(1); // jalr clears bit 0
		else
			target4 = pc + bImm;
	end

	assign isStore4   = memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw};
	assign memOffset4 = isStore4 ? sImm : opB; // opB holds the I-imm on loads

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			opA5      <= '0;
			opB5      <= '0;
			rd5       <= '0;
			we5       <= 1'b0;
			aluOp5    <= exePkg::aluAdd;
			wbSel5    <= exePkg::wbAlu;
			brCond5   <= exePkg::brEq;
			mulDivOp5 <= exePkg::mdMul;
			isBranch5 <= 1'b0;
			isJump5   <= 1'b0;
			target5   <= '0;
			uImm5     <= '0;
			pc5       <= '0;
		end
		else
		begin
			opA5      <= opA;
			opB5      <= opB;
			rd5       <= rd;
			we5       <= we;
			aluOp5    <= aluOp;
			wbSel5    <= wbSel;
			brCond5   <= brCond;
			mulDivOp5 <= mulDivOp;
			isBranch5 <= isBranch;
			isJump5   <= isJal | isJalr;
			target5   <= target4;
			uImm5     <= uImm;
			pc5       <= pc;
		end
	end

	exeAlu alu (
		.op       (aluOp5),
		.a        (opA5),
		.b        (opB5),
		.brCond   (brCond5),
		.result   (aluRes5),
		.condTrue (condTrue5)
	);

	mulDiv md (
		.op  (mulDivOp5),
		.a   (opA5),
		.b   (opB5),
		.res (mulDivRes5)
	);

	dataMem #(
		.dmemWords (dmemWords)
	) dmem (
		.clk             (clk),
		.nrst            (nrst),
		.memOp           (memOp),
		.base            (opA),
		.storeData       (opB),
		.offset          (memOffset4),
		.memOut6         (memOut6),
		.addrMisaligned6 (addrMisaligned6)
	);

	assign redirect = isJump5 | (isBranch5 & condTrue5);
	assign target   = target5;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			aluRes6    <= '0;
			mulDivRes6 <= '0;
			pc6        <= '0;
			uImm6      <= '0;
			auipc6     <= '0;
			wbSel6     <= exePkg::wbAlu;
			rd6        <= '0;
			we6        <= 1'b0;
		end
		else
		begin
			aluRes6    <= aluRes5;
			mulDivRes6 <= mulDivRes5;
			pc6        <= pc5;
			uImm6      <= uImm5;
			auipc6     <= pc5 + uImm5;
			wbSel6     <= wbSel5;
			rd6        <= rd5;
			we6        <= we5;
		end
	end

	always_comb
	begin
		unique case (wbSel6)
			exePkg::wbAlu:    wbData = aluRes6;
			exePkg::wbLink:   wbData = pc6 + 4; // return address
			exePkg::wbMulDiv: wbData = mulDivRes6;
			exePkg::wbUpper:  wbData = uImm6;
			exePkg::wbMem:    wbData = memOut6;
			exePkg::wbAuipc:  wbData = auipc6;
			default:          wbData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- exeStage_checker.sv
`default_nettype none

module exeStage_checker #(
	parameter int dmemWords = 256
) (
	input logic                         clk,
	input logic                         nrst,
	input logic                         we6,
	input logic                         redirect,
	input logic [31:0]                  target,
	input logic                         badStore,
	input logic [$clog2(dmemWords)-1:0] wordIdx,
	input logic [31:0]                  memArr [dmemWords]
);

	timeunit 1ns;
	timeprecision 100ps;

	// first edge after reset release
	resetClean: assert property (@(posedge clk) $rose(nrst) |-> (!we6 && !redirect))
		else $error("we6 or redirect high in the cycle after reset release");

	storeHeld: assert property (@(posedge clk) disable iff (!nrst)
		badStore |=> memArr[$past(wordIdx)] == $past(memArr[wordIdx]))
		else $error("misaligned store changed the addressed memory word");

	targetEven: assert property (@(posedge clk) disable iff (!nrst) redirect |-> !target[0])
		else $error("redirect taken with an odd target");

endmodule

bind exeStage exeStage_checker #(.dmemWords(dmemWords)) chk (
	.clk      (clk),
	.nrst     (nrst),
	.we6      (we6),
	.redirect (redirect),
	.target   (target),
	.badStore (dmem.misaligned && (dmem.byteEn != 4'b0000)),
	.wordIdx  (dmem.wordIdx),
	.memArr   (dmem.mem)
);

`default_nettype wire

//--- exeTb.sv
`default_nettype none

module exeTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numOps = 400;
	localparam int fillOps = 64; // one store per word of the window
	localparam int resetCycles = 4;
	localparam int cycleLimit = resetCycles + fillOps + numOps + 20;

	logic clk;
	logic nrst;
	logic [31:0] opA, opB, bImm, jImm, uImm, sImm, pc;
	logic [4:0] rd;
	logic we, isBranch, isJal, isJalr;
	exePkg::aluOpE aluOp;
	exePkg::wbSelE wbSel;
	exePkg::brCondE brCond;
	exePkg::memOpE memOp;
	exePkg::mulDivOpE mulDivOp;
	logic [31:0] wbData, memOut6, target;
	logic [4:0] rd6;
	logic we6, addrMisaligned6, redirect;

	int cycle = 0;
	int errWb = 0;
	int errRedir = 0;
	int errMem = 0;
	logic [7:0] model [256];

	// expected entries per issued op
	int wbDueQ[$];
	logic [31:0] wbValQ[$];
	logic wbKnownQ[$];
	logic weQ[$];
	logic [4:0] rdQ[$];
	logic [31:0] memValQ[$];
	logic memKnownQ[$];
	logic misQ[$];
	int redirDueQ[$];
	logic redirQ[$];
	logic [31:0] tgtQ[$];

	exePkg::brCondE conds [6] = '{exePkg::brEq, exePkg::brNe, exePkg::brLt,
		exePkg::brGe, exePkg::brLtu, exePkg::brGeu};

	exeStage #(.dmemWords(256)) DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle++;
		if (cycle > cycleLimit)
		begin
			$display("timeout: results still outstanding after %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic signedLess(input logic [31:0] a, input logic [31:0] b);
		return (a[31] != b[31]) ? a[31] : (a < b);
	endfunction

	function automatic logic [31:0] aluResult(input exePkg::aluOpE op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] ext;
		ext = {{32{a[31]}}, a} >> b[4:0];
		case (op)
			exePkg::aluAdd:  return a + b;
			exePkg::aluSub:  return a - b;
			exePkg::aluSll:  return a << b[4:0];
			exePkg::aluSlt:  return {31'b0, signedLess(a, b)};
			exePkg::aluSltu: return {31'b0, a < b};
			exePkg::aluXor:  return a ^ b;
			exePkg::aluSrl:  return a >> b[4:0];
			exePkg::aluSra:  return ext[31:0];
			exePkg::aluOr:   return a | b;
			default:         return a & b;
		endcase
	endfunction

	function automatic logic [31:0] mulDivResult(input exePkg::mulDivOpE op,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] ax, bx, p;
		logic [31:0] qa, qb, q, r;
		logic ovf;
		ax = (op == exePkg::mdMulh || op == exePkg::mdMulhsu) ? {{32{a[31]}}, a} : {32'b0, a};
		bx = (op == exePkg::mdMulh) ? {{32{b[31]}}, b} : {32'b0, b};
		p = ax * bx; // low 64 bits are exact for either signedness
		qa = a[31] ? -a : a;
		qb = b[31] ? -b : b;
		q = (b != 0) ? qa / qb : 32'd0;
		r = (b != 0) ? qa % qb : 32'd0;
		ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			exePkg::mdMul:  return p[31:0];
			exePkg::mdDiv:  return (b == 0) ? 32'hffff_ffff : ovf ? a : ((a[31] ^ b[31]) ? -q : q);
			exePkg::mdDivu: return (b == 0) ? 32'hffff_ffff : a / b;
			exePkg::mdRem:  return (b == 0) ? a : ovf ? 32'd0 : (a[31] ? -r : r);
			exePkg::mdRemu: return (b == 0) ? a : a % b;
			default:        return p[63:32];
		endcase
	endfunction

	function automatic logic branchTaken(input exePkg::brCondE c, input logic [31:0] a,
		input logic [31:0] b);
		case (c)
			exePkg::brEq:  return a == b;
			exePkg::brNe:  return a != b;
			exePkg::brLt:  return signedLess(a, b);
			exePkg::brGe:  return !signedLess(a, b);
			exePkg::brLtu: return a < b;
			default:       return a >= b;
		endcase
	endfunction

	// aligned accesses only
	function automatic logic [31:0] loadValue(input exePkg::memOpE op, input logic [7:0] addr);
		logic [7:0] b0, b1;
		b0 = model[addr];
		b1 = model[8'(addr + 1)];
		case (op)
			exePkg::memLb:  return {{24{b0[7]}}, b0};
			exePkg::memLbu: return {24'b0, b0};
			exePkg::memLh:  return {{16{b1[7]}}, b1, b0};
			exePkg::memLhu: return {16'b0, b1, b0};
			default:        return {model[addr + 3], model[addr + 2], b1, b0};
		endcase
	endfunction

	function automatic logic [31:0] pickOperand();
		case ($urandom % 8)
			0:       return 32'h0000_0000;
			1:       return 32'h8000_0000;
			2:       return 32'hffff_ffff;
			3:       return 32'h7fff_ffff;
			default: return $urandom;
		endcase
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0000;
	endfunction

	task automatic storeModel(input exePkg::memOpE op, input logic [7:0] addr,
		input logic [31:0] data);
		int n;
		n = (op == exePkg::memSb) ? 1 : (op == exePkg::memSh) ? 2 : 4;
		for (int i = 0; i < n; i++)
			model[8'(addr + i)] = data[8*i +: 8];
	endtask

	task automatic bubble();
		opA = '0;
		opB = '0;
		bImm = '0;
		jImm = '0;
		uImm = '0;
		sImm = '0;
		pc = '0;
		rd = '0;
		we = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		isJalr = 1'b0;
		aluOp = exePkg::aluAdd;
		wbSel = exePkg::wbAlu;
		brCond = exePkg::brEq;
		memOp = exePkg::memNone;
		mulDivOp = exePkg::mdMul;
	endtask

	task automatic pushExpect(input logic [31:0] wbExp, input logic wbKnown,
		input logic [31:0] memExp, input logic memKnown, input logic misExp,
		input logic redirExp, input logic [31:0] tgtExp);
		wbDueQ.push_back(cycle + 2); // out two edges after launch
		wbValQ.push_back(wbExp);
		wbKnownQ.push_back(wbKnown);
		weQ.push_back(we);
		rdQ.push_back(rd);
		memValQ.push_back(memExp);
		memKnownQ.push_back(memKnown);
		misQ.push_back(misExp);
		redirDueQ.push_back(cycle + 1);
		redirQ.push_back(redirExp);
		tgtQ.push_back(tgtExp);
	endtask

	task automatic memOpRandom();
		logic [7:0] addr;
		logic [31:0] off;
		logic mis;
		logic [31:0] v;
		memOp = exePkg::memOpE'(1 + $urandom % 8);
		addr = 8'($urandom);
		if ($urandom % 4 != 0)
		begin
			if (memOp inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh})
				addr[0] = 1'b0;
			else if (memOp inside {exePkg::memLw, exePkg::memSw})
				addr[1:0] = 2'b00;
		end
		mis = (memOp inside {exePkg::memLh, exePkg::memLhu, exePkg::memSh}) ? addr[0] :
			(memOp inside {exePkg::memLw, exePkg::memSw}) ? |addr[1:0] : 1'b0;
		off = 32'($urandom % 64) - 32; // signed offset around the address
		opA = {24'b0, addr} - off;
		if (memOp inside {exePkg::memSb, exePkg::memSh, exePkg::memSw})
		begin
			sImm = off;
			opB = $urandom;
			if (!mis)
				storeModel(memOp, addr, opB);
			pushExpect('0, 1'b0, '0, 1'b1, mis, 1'b0, '0);
		end
		else
		begin
			opB = off;
			wbSel = exePkg::wbMem;
			we = 1'b1;
			if (mis)
				pushExpect('0, 1'b0, '0, 1'b0, 1'b1, 1'b0, '0);
			else
			begin
				v = loadValue(memOp, addr);
				pushExpect(v, 1'b1, v, 1'b1, 1'b0, 1'b0, '0);
			end
		end
	endtask

	task automatic randomOp();
		logic [31:0] tgt;
		bubble();
		pc = $urandom & 32'h0000_fffc;
		rd = 5'($urandom);
		opA = pickOperand();
		opB = pickOperand();
		case ($urandom % 6)
			0:
			begin
				aluOp = exePkg::aluOpE'($urandom % 10);
				we = 1'b1;
				pushExpect(aluResult(aluOp, opA, opB), 1'b1, '0, 1'b1, 1'b0, 1'b0, '0);
			end
			1:
			begin
				mulDivOp = exePkg::mulDivOpE'($urandom % 8);
				wbSel = exePkg::wbMulDiv;
				we = 1'b1;
				pushExpect(mulDivResult(mulDivOp, opA, opB), 1'b1, '0, 1'b1, 1'b0, 1'b0, '0);
			end
			2:
			begin
				uImm = $urandom & 32'hffff_f000;
				we = 1'b1;
				wbSel = ($urandom % 2) ? exePkg::wbUpper : exePkg::wbAuipc;
				pushExpect((wbSel == exePkg::wbUpper) ? uImm : pc + uImm, 1'b1, '0, 1'b1,
					1'b0, 1'b0, '0);
			end
			3:
			begin
				we = 1'b1;
				wbSel = exePkg::wbLink;
				if ($urandom % 2)
				begin
					isJal = 1'b1;
					jImm = $urandom & 32'hffff_fffe;
					tgt = pc + jImm;
				end
				else
				begin
					isJalr = 1'b1;
					tgt = (opA + opB) & 32'hffff_fffe;
				end
				pushExpect(pc + 4, 1'b1, '0, 1'b1, 1'b0, 1'b1, tgt);
			end
			4:
			begin
				isBranch = 1'b1;
				brCond = conds[$urandom % 6];
				bImm = $urandom & 32'h0000_1ffe;
				if ($urandom % 3 == 0)
					opB = opA; // equal operands hit the eq and ge edges
				pushExpect('0, 1'b0, '0, 1'b1, 1'b0, branchTaken(brCond, opA, opB), pc + bImm);
			end
			default: memOpRandom();
		endcase
	endtask

	// compare mid-cycle where outputs are stable
	always @(posedge clk)
	begin
		logic e;
		logic [31:0] t;
		#2;
		while (redirDueQ.size() > 0 && redirDueQ[0] == cycle)
		begin
			void'(redirDueQ.pop_front());
			e = redirQ.pop_front();
			t = tgtQ.pop_front();
			assert (redirect === e)
			else
			begin
				$display("[FAIL] %0t redirect exp %b got %b", $time, e, redirect);
				errRedir++;
			end
			if (e)
				assert (target === t)
				else
				begin
					$display("[FAIL] %0t target exp %h got %h", $time, t, target);
					errRedir++;
				end
		end
		while (wbDueQ.size() > 0 && wbDueQ[0] == cycle)
		begin
			void'(wbDueQ.pop_front());
			e = weQ.pop_front();
			assert (we6 === e)
			else
			begin
				$display("[FAIL] %0t we6 exp %b got %b", $time, e, we6);
				errWb++;
			end
			t = 32'(rdQ.pop_front());
			if (e)
				assert (rd6 === t[4:0])
				else
				begin
					$display("[FAIL] %0t rd6 exp %0d got %0d", $time, t[4:0], rd6);
					errWb++;
				end
			t = wbValQ.pop_front();
			if (wbKnownQ.pop_front())
				assert (wbData === t)
				else
				begin
					$display("[FAIL] %0t wbData exp %h got %h", $time, t, wbData);
					errWb++;
				end
			t = memValQ.pop_front();
			if (memKnownQ.pop_front())
				assert (memOut6 === t)
				else
				begin
					$display("[FAIL] %0t memOut6 exp %h got %h", $time, t, memOut6);
					errMem++;
				end
			e = misQ.pop_front();
			assert (addrMisaligned6 === e)
			else
			begin
				$display("[FAIL] %0t addrMisaligned6 exp %b got %b", $time, e, addrMisaligned6);
				errMem++;
			end
		end
	end

	initial
	begin
		void'($urandom(71));
		nrst = 1'b0;
		bubble();
		repeat (resetCycles) @(posedge clk);
		#0.5 nrst = 1'b1;
		// known contents for the 64-word window
		for (int i = 0; i < fillOps; i++)
		begin
			@(posedge clk);
			#0.5;
			bubble();
			memOp = exePkg::memSw;
			opA = 32'(4 * i);
			opB = fillWord(opA);
			storeModel(memOp, opA[7:0], opB);
			pushExpect('0, 1'b0, '0, 1'b1, 1'b0, 1'b0, '0);
		end
		for (int i = 0; i < numOps; i++)
		begin
			@(posedge clk);
			#0.5;
			randomOp();
		end
		@(posedge clk);
		#0.5 bubble();
		while (wbDueQ.size() > 0 || redirDueQ.size() > 0)
			@(posedge clk);
		#3;
		$display("errors: wb %0d, redirect %0d, mem %0d", errWb, errRedir, errMem);
		if (errWb + errRedir + errMem == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
exePkg.sv
exeAlu.sv
mulDiv.sv
dataMem.sv
exeStage.sv
exeStage_checker.sv
exeTb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f project.f --top-module exeTb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f project.f --top-module exeTb
	./obj_dir/VexeTb > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
